//--- Makefile
TOP = tb_lane_template
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_clock_gen.sv
// Free-running 20 ns clock with reset held high for the first 8 cycles
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Released on a falling edge like the rest of the stimulus
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule : tb_clock_gen

//--- bench/tb_lane_template.sv
// Packets go out at least LANE_NUM_ENGINES cycles apart and memory acks come 1 to 6 cycles late
`include "lane_defs.svh"

module tb_lane_template;
    timeunit 1ns;
    timeprecision 1ps;

    import lane_pkg::*;

    localparam int N       = `LANE_NUM_ENGINES;
    localparam int PKT_GAP = 4;
    // 11 packets x 4 engines x 6 cycles of ack delay, plus gaps and idle waits, with wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic       ap_clk;
    logic       areset;
    logic       desc_valid_i;
    addr_t      desc_base_i;
    count_t     desc_count_i;
    logic       lane_valid_i;
    vertex_t    lane_vertex_i;
    value_t     lane_value_i;
    logic       mem_ack_valid_i = 1'b0;
    engine_id_t mem_ack_id_i    = '0;
    logic       lane_valid_o;
    vertex_t    lane_vertex_o;
    value_t     lane_value_o;
    logic       mem_req_valid_o;
    addr_t      mem_req_addr_o;
    value_t     mem_req_data_o;
    engine_id_t mem_req_id_o;
    logic       done_o;

    int     cycle = 0;
    int     errors;
    int     test_errors;
    int     tests_run;
    integer seed;

    // Packets sent and responses seen during the current run
    vertex_t    sent_vertex_q [$];
    value_t     sent_value_q  [$];
    int         sent_cycle_q  [$];
    vertex_t    out_vertex_q  [$];
    value_t     out_value_q   [$];
    int         out_cycle_q   [$];
    addr_t      req_addr_q    [$];
    value_t     req_data_q    [$];
    engine_id_t req_id_q      [$];

    // Pending acks with strictly rising due cycles
    int         ack_due_q [$];
    engine_id_t ack_id_q  [$];
    int         last_due  = 0;
    int         acks_sent;
    int         last_ack_cycle;

    int   desc_cycle;
    int   done_fall_cycle;
    int   done_rise_cycle;
    int   done_rises;
    logic done_prev = 1'b1;

    tb_clock_gen u_tb_clock_gen (
        .clk_o(ap_clk),
        .rst_o(areset)
    );

    lane_template u_lane_template (
        .ap_clk         (ap_clk),
        .areset         (areset),
        .desc_valid_i   (desc_valid_i),
        .desc_base_i    (desc_base_i),
        .desc_count_i   (desc_count_i),
        .lane_valid_i   (lane_valid_i),
        .lane_vertex_i  (lane_vertex_i),
        .lane_value_i   (lane_value_i),
        .mem_ack_valid_i(mem_ack_valid_i),
        .mem_ack_id_i   (mem_ack_id_i),
        .lane_valid_o   (lane_valid_o),
        .lane_vertex_o  (lane_vertex_o),
        .lane_value_o   (lane_value_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_addr_o (mem_req_addr_o),
        .mem_req_data_o (mem_req_data_o),
        .mem_req_id_o   (mem_req_id_o),
        .done_o         (done_o)
    );

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Output monitor and memory model
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        int due;
        if (lane_valid_o) begin
            out_vertex_q.push_back(lane_vertex_o);
            out_value_q.push_back(lane_value_o);
            out_cycle_q.push_back(cycle);
        end
        if (mem_req_valid_o) begin
            req_addr_q.push_back(mem_req_addr_o);
            req_data_q.push_back(mem_req_data_o);
            req_id_q.push_back(mem_req_id_o);
            due = cycle + 1 + int'($unsigned($random(seed)) % 6);
            // One ack per cycle at most
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            ack_due_q.push_back(due);
            ack_id_q.push_back(mem_req_id_o);
        end
        if (ack_due_q.size() > 0 && ack_due_q[0] <= cycle) begin
            void'(ack_due_q.pop_front());
            mem_ack_valid_i = 1'b1;
            mem_ack_id_i    = ack_id_q.pop_front();
            acks_sent++;
            last_ack_cycle = cycle;
        end
        else begin
            mem_ack_valid_i = 1'b0;
        end
        if (done_prev && !done_o) begin
            done_fall_cycle = cycle;
        end
        if (!done_prev && done_o) begin
            done_rise_cycle = cycle;
            done_rises++;
        end
        done_prev = done_o;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", name);
        end
        else begin
            $display("Test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic clear_logs();
        sent_vertex_q.delete();
        sent_value_q.delete();
        sent_cycle_q.delete();
        out_vertex_q.delete();
        out_value_q.delete();
        out_cycle_q.delete();
        req_addr_q.delete();
        req_data_q.delete();
        req_id_q.delete();
        acks_sent       = 0;
        done_rises      = 0;
        done_fall_cycle = -1;
        done_rise_cycle = -1;
    endtask

    task automatic send_packet(input vertex_t vertex, input value_t value);
        @(negedge ap_clk);
        lane_valid_i  = 1'b1;
        lane_vertex_i = vertex;
        lane_value_i  = value;
        sent_vertex_q.push_back(vertex);
        sent_value_q.push_back(value);
        sent_cycle_q.push_back(cycle);
        @(negedge ap_clk);
        lane_valid_i = 1'b0;
        repeat (PKT_GAP - 2) @(negedge ap_clk);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_idle();
        repeat (20) begin
            @(negedge ap_clk);
            check_value("done_o after reset", done_o, 1);
            check_value("lane_valid_o after reset", lane_valid_o, 0);
            check_value("mem_req_valid_o after reset", mem_req_valid_o, 0);
        end
        finish_test("reset_idle");
    endtask

    task automatic test_passthrough(input string name, input addr_t base, input count_t count);
        clear_logs();
        @(negedge ap_clk);
        desc_valid_i = 1'b1;
        desc_base_i  = base;
        desc_count_i = count;
        desc_cycle   = cycle;
        @(negedge ap_clk);
        desc_valid_i = 1'b0;
        // Give run_active time to rise
        @(negedge ap_clk);
        for (int i = 0; i < int'(count); i++) begin
            send_packet(vertex_t'($random(seed)), value_t'($random(seed)));
        end
        while (out_vertex_q.size() < int'(count)) @(negedge ap_clk);
        repeat (PKT_GAP) @(negedge ap_clk);
        check_value("lane output count", out_vertex_q.size(), count);
        for (int i = 0; i < int'(count) && i < out_vertex_q.size(); i++) begin
            check_value($sformatf("lane vertex %0d", i), out_vertex_q[i], sent_vertex_q[i]);
            check_value($sformatf("lane value %0d", i), out_value_q[i], sent_value_q[i]);
            check_value($sformatf("lane latency %0d", i), out_cycle_q[i] - sent_cycle_q[i], N + 2);
        end
        finish_test(name);
    endtask

    task automatic test_scatter(input string name, input addr_t base, input count_t count);
        int    seen;
        addr_t exp_addr;
        while (!done_o) @(negedge ap_clk);
        check_value("request count", req_addr_q.size(), int'(count) * N);
        for (int id = 0; id < N; id++) begin
            seen = 0;
            for (int r = 0; r < req_addr_q.size(); r++) begin
                if (int'(req_id_q[r]) == id) begin
                    if (seen < int'(count)) begin
                        exp_addr = base + addr_t'(id * `LANE_REGION_WORDS)
                                 + addr_t'(sent_vertex_q[seen]);
                        check_value($sformatf("engine %0d address %0d", id, seen),
                                    req_addr_q[r], exp_addr);
                        check_value($sformatf("engine %0d data %0d", id, seen),
                                    req_data_q[r], sent_value_q[seen]);
                    end
                    seen++;
                end
            end
            check_value($sformatf("engine %0d request count", id), seen, count);
        end
        finish_test(name);
    endtask

    task automatic test_completion(input string name, input count_t count);
        while (!done_o) @(negedge ap_clk);
        repeat (4) @(negedge ap_clk);
        check_value("acks sent", acks_sent, int'(count) * N);
        check_value("done_o fall cycle", done_fall_cycle, desc_cycle + 2);
        check_value("done_o rises in run", done_rises, 1);
        check_value("done_o rise cycle", done_rise_cycle, last_ack_cycle + 3);
        finish_test(name);
    endtask

    task automatic test_idle_drop();
        clear_logs();
        for (int i = 0; i < 3; i++) begin
            send_packet(vertex_t'($random(seed)), value_t'($random(seed)));
        end
        repeat (N + 8) @(negedge ap_clk);
        check_value("lane outputs while idle", out_vertex_q.size(), 0);
        check_value("requests while idle", req_addr_q.size(), 0);
        check_value("done_o while idle", done_o, 1);
        finish_test("idle_drop");
    endtask

    initial begin
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        seed          = 32'h8dd11854;
        desc_valid_i  = 1'b0;
        desc_base_i   = '0;
        desc_count_i  = '0;
        lane_valid_i  = 1'b0;
        lane_vertex_i = '0;
        lane_value_i  = '0;
        wait (areset === 1'b0);
        // Internal reset copy lags by one cycle
        repeat (4) @(negedge ap_clk);

        test_reset_idle();
        test_passthrough("passthrough", 32'h0100_0000, 16'd5);
        test_scatter("scatter", 32'h0100_0000, 16'd5);
        test_completion("completion", 16'd5);
        test_idle_drop();
        test_passthrough("passthrough_run2", 32'h2000_0000, 16'd3);
        test_scatter("scatter_run2", 32'h2000_0000, 16'd3);
        test_completion("completion_run2", 16'd3);

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule : tb_lane_template

//--- build.f
+incdir+design
design/lane_pkg.sv
design/sync_fifo.sv
design/lane_control.sv
design/lane_engine.sv
design/memory_request_arbiter.sv
design/lane_template.sv
bench/tb_clock_gen.sv
bench/tb_lane_template.sv

//--- design/lane_control.sv
// Descriptors during a run are dropped and a zero packet count ends the run at once
`include "lane_defs.svh"

module lane_control (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  logic                         desc_valid_i,
    input  lane_pkg::addr_t              desc_base_i,
    input  lane_pkg::count_t             desc_count_i,
    input  logic [`LANE_NUM_ENGINES-1:0] engine_done_i,
    output logic                         run_active_o,
    output lane_pkg::addr_t              desc_base_o,
    output lane_pkg::count_t             desc_count_o,
    output logic                         done_o
);

    import lane_pkg::*;

    run_state_e state;
    run_state_e state_next;
    logic       all_done;
    logic       accept;

    assign all_done = &engine_done_i;
    assign accept   = (state == RUN_IDLE) && desc_valid_i;

    always_comb begin
        state_next = state;
        case (state)
            RUN_IDLE: begin
                if (desc_valid_i) begin
                    state_next = RUN_ACTIVE;
                end
            end
            RUN_ACTIVE: begin
                if (all_done) begin
                    state_next = RUN_DRAIN;
                end
            end
            default: state_next = RUN_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state <= RUN_IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    // Base and count held for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            desc_base_o  <= desc_base_i;
            desc_count_o <= desc_count_i;
        end
    end

    assign run_active_o = (state == RUN_ACTIVE);

    // Low from the accepted descriptor until every engine has its acks
    assign done_o = ((state == RUN_IDLE) && !desc_valid_i)
                  || ((state == RUN_ACTIVE) && all_done)
                  || (state == RUN_DRAIN);

endmodule : lane_control

//--- design/lane_defs.svh
// Engine count must be at least 2 and lane packets must be spaced that many cycles apart
`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Lane shape
`define LANE_NUM_ENGINES    4
`define LANE_REQ_FIFO_DEPTH 8

// Field widths
`define LANE_VERTEX_W 16
`define LANE_VALUE_W  32
`define LANE_ADDR_W   32
`define LANE_COUNT_W  16

// Memory words owned by each engine
`define LANE_REGION_WORDS 65536

`endif

//--- design/lane_engine.sv
// Packets must arrive at least LANE_NUM_ENGINES cycles apart and only acks with this id count
`include "lane_defs.svh"

module lane_engine #(
    parameter int ENGINE_ID = 0
) (
    input  logic                 ap_clk,
    input  logic                 areset_lane_template,
    input  logic                 run_active_i,
    input  lane_pkg::addr_t      desc_base_i,
    input  lane_pkg::count_t     desc_count_i,
    input  logic                 pkt_valid_i,
    input  lane_pkg::vertex_t    pkt_vertex_i,
    input  lane_pkg::value_t     pkt_value_i,
    input  logic                 ack_valid_i,
    input  lane_pkg::engine_id_t ack_id_i,
    output logic                 pkt_valid_o,
    output lane_pkg::vertex_t    pkt_vertex_o,
    output lane_pkg::value_t     pkt_value_o,
    output logic                 wr_valid_o,
    output lane_pkg::addr_t      wr_addr_o,
    output lane_pkg::value_t     wr_data_o,
    output logic                 engine_done_o
);

    import lane_pkg::*;

    // First word of this engine's output region
    localparam addr_t REGION_BASE = addr_t'(ENGINE_ID * `LANE_REGION_WORDS);

    logic   accept;
    logic   ack_hit;
    count_t ack_count;

    // --------------------------------------------------
    // Packet stage
    // --------------------------------------------------
    // Idle packets die here
    assign accept = pkt_valid_i && run_active_i;

    // Forward and write strobe leave on the same edge
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            pkt_valid_o <= 1'b0;
            wr_valid_o  <= 1'b0;
        end
        else begin
            pkt_valid_o <= accept;
            wr_valid_o  <= accept;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            pkt_vertex_o <= pkt_vertex_i;
            pkt_value_o  <= pkt_value_i;
            wr_addr_o    <= desc_base_i + REGION_BASE + addr_t'(pkt_vertex_i);
            wr_data_o    <= pkt_value_i;
        end
    end

    // --------------------------------------------------
    // Acknowledge count
    // --------------------------------------------------
    assign ack_hit = ack_valid_i && (ack_id_i == engine_id_t'(ENGINE_ID));

    // Held at zero between runs so each run starts clean
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template || !run_active_i) begin
            ack_count <= '0;
        end
        else if (ack_hit) begin
            ack_count <= ack_count + 1'b1;
        end
    end

    assign engine_done_o = run_active_i && (ack_count == desc_count_i);

endmodule : lane_engine

//--- design/lane_pkg.sv
// Widths come from the lane macros and engine_id_t needs at least 2 engines
`include "lane_defs.svh"

package lane_pkg;

    typedef logic [`LANE_VERTEX_W-1:0] vertex_t;
    typedef logic [`LANE_VALUE_W-1:0]  value_t;
    typedef logic [`LANE_ADDR_W-1:0]   addr_t;
    typedef logic [`LANE_COUNT_W-1:0]  count_t;

    // Index of one engine in the chain
    typedef logic [$clog2(`LANE_NUM_ENGINES)-1:0] engine_id_t;

    // Run progress held by lane_control
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_DRAIN
    } run_state_e;

endpackage : lane_pkg

//--- design/lane_template.sv
// Lane packets must be spaced at least LANE_NUM_ENGINES cycles apart as no port has back-pressure
`include "lane_defs.svh"

module lane_template (
    input  logic                 ap_clk,
    input  logic                 areset,
    input  logic                 desc_valid_i,
    input  lane_pkg::addr_t      desc_base_i,
    input  lane_pkg::count_t     desc_count_i,
    input  logic                 lane_valid_i,
    input  lane_pkg::vertex_t    lane_vertex_i,
    input  lane_pkg::value_t     lane_value_i,
    input  logic                 mem_ack_valid_i,
    input  lane_pkg::engine_id_t mem_ack_id_i,
    output logic                 lane_valid_o,
    output lane_pkg::vertex_t    lane_vertex_o,
    output lane_pkg::value_t     lane_value_o,
    output logic                 mem_req_valid_o,
    output lane_pkg::addr_t      mem_req_addr_o,
    output lane_pkg::value_t     mem_req_data_o,
    output lane_pkg::engine_id_t mem_req_id_o,
    output logic                 done_o
);

    import lane_pkg::*;

    localparam int N = `LANE_NUM_ENGINES;

    // --------------------------------------------------
    // Wires and registers
    // --------------------------------------------------
    logic areset_lane_template;

    logic       desc_valid_reg;
    addr_t      desc_base_reg;
    count_t     desc_count_reg;
    logic       lane_valid_reg;
    vertex_t    lane_vertex_reg;
    value_t     lane_value_reg;
    logic       ack_valid_reg;
    engine_id_t ack_id_reg;

    logic         run_active;
    addr_t        desc_base;
    count_t       desc_count;
    logic         ctrl_done;
    logic [N-1:0] engine_done;

    // Slot k feeds engine k, slot N leaves the lane
    logic    chain_valid  [N+1];
    vertex_t chain_vertex [N+1];
    value_t  chain_value  [N+1];

    logic [N-1:0] wr_valid;
    addr_t        wr_addr [N];
    value_t       wr_data [N];

    logic       arb_valid;
    addr_t      arb_addr;
    value_t     arb_data;
    engine_id_t arb_id;

    always_ff @(posedge ap_clk) begin
        areset_lane_template <= areset;
    end

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            desc_valid_reg <= 1'b0;
            lane_valid_reg <= 1'b0;
            ack_valid_reg  <= 1'b0;
        end
        else begin
            desc_valid_reg <= desc_valid_i;
            lane_valid_reg <= lane_valid_i;
            ack_valid_reg  <= mem_ack_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_base_reg   <= desc_base_i;
        desc_count_reg  <= desc_count_i;
        lane_vertex_reg <= lane_vertex_i;
        lane_value_reg  <= lane_value_i;
        ack_id_reg      <= mem_ack_id_i;
    end

    // --------------------------------------------------
    // Control and engine chain
    // --------------------------------------------------
    lane_control u_lane_control (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .desc_valid_i        (desc_valid_reg),
        .desc_base_i         (desc_base_reg),
        .desc_count_i        (desc_count_reg),
        .engine_done_i       (engine_done),
        .run_active_o        (run_active),
        .desc_base_o         (desc_base),
        .desc_count_o        (desc_count),
        .done_o              (ctrl_done)
    );

    assign chain_valid[0]  = lane_valid_reg;
    assign chain_vertex[0] = lane_vertex_reg;
    assign chain_value[0]  = lane_value_reg;

    for (genvar k = 0; k < N; k++) begin : g_engine
        lane_engine #(
            .ENGINE_ID(k)
        ) u_lane_engine (
            .ap_clk              (ap_clk),
            .areset_lane_template(areset_lane_template),
            .run_active_i        (run_active),
            .desc_base_i         (desc_base),
            .desc_count_i        (desc_count),
            .pkt_valid_i         (chain_valid[k]),
            .pkt_vertex_i        (chain_vertex[k]),
            .pkt_value_i         (chain_value[k]),
            .ack_valid_i         (ack_valid_reg),
            .ack_id_i            (ack_id_reg),
            .pkt_valid_o         (chain_valid[k+1]),
            .pkt_vertex_o        (chain_vertex[k+1]),
            .pkt_value_o         (chain_value[k+1]),
            .wr_valid_o          (wr_valid[k]),
            .wr_addr_o           (wr_addr[k]),
            .wr_data_o           (wr_data[k]),
            .engine_done_o       (engine_done[k])
        );
    end

    memory_request_arbiter u_memory_request_arbiter (
        .ap_clk              (ap_clk),
        .areset_lane_template(areset_lane_template),
        .wr_valid_i          (wr_valid),
        .wr_addr_i           (wr_addr),
        .wr_data_i           (wr_data),
        .mem_req_valid_o     (arb_valid),
        .mem_req_addr_o      (arb_addr),
        .mem_req_data_o      (arb_data),
        .mem_req_id_o        (arb_id)
    );

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            lane_valid_o    <= 1'b0;
            mem_req_valid_o <= 1'b0;
            done_o          <= 1'b1;
        end
        else begin
            lane_valid_o    <= chain_valid[N];
            mem_req_valid_o <= arb_valid;
            done_o          <= ctrl_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        lane_vertex_o  <= chain_vertex[N];
        lane_value_o   <= chain_value[N];
        mem_req_addr_o <= arb_addr;
        mem_req_data_o <= arb_data;
        mem_req_id_o   <= arb_id;
    end

endmodule : lane_template

//--- design/memory_request_arbiter.sv
// FIFO overflow is not detected so lane packets must stay LANE_NUM_ENGINES cycles apart
`include "lane_defs.svh"

module memory_request_arbiter (
    input  logic                         ap_clk,
    input  logic                         areset_lane_template,
    input  logic [`LANE_NUM_ENGINES-1:0] wr_valid_i,
    input  lane_pkg::addr_t              wr_addr_i [`LANE_NUM_ENGINES],
    input  lane_pkg::value_t             wr_data_i [`LANE_NUM_ENGINES],
    output logic                         mem_req_valid_o,
    output lane_pkg::addr_t              mem_req_addr_o,
    output lane_pkg::value_t             mem_req_data_o,
    output lane_pkg::engine_id_t         mem_req_id_o
);

    import lane_pkg::*;

    localparam int N     = `LANE_NUM_ENGINES;
    localparam int REQ_W = $bits(addr_t) + $bits(value_t);

    logic [N-1:0]     fifo_empty;
    logic [N-1:0]     fifo_pop;
    logic [REQ_W-1:0] fifo_dout [N];
    engine_id_t       last_grant;
    engine_id_t       grant_idx;
    logic             grant_valid;

    for (genvar k = 0; k < N; k++) begin : g_req_fifo
        sync_fifo #(
            .WIDTH(REQ_W),
            .DEPTH(`LANE_REQ_FIFO_DEPTH)
        ) u_req_fifo (
            .ap_clk              (ap_clk),
            .areset_lane_template(areset_lane_template),
            .push_i              (wr_valid_i[k]),
            .push_data_i         ({wr_addr_i[k], wr_data_i[k]}),
            .pop_i               (fifo_pop[k]),
            .pop_data_o          (fifo_dout[k]),
            .empty_o             (fifo_empty[k])
        );

        assign fifo_pop[k] = grant_valid && (grant_idx == engine_id_t'(k));
    end

    // Nearest non-empty FIFO after the last grant wins
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        cand        = 0;
        for (int off = N; off >= 1; off--) begin
            cand = (int'(last_grant) + off) % N;
            if (!fifo_empty[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = engine_id_t'(cand);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            mem_req_valid_o <= 1'b0;
            last_grant      <= engine_id_t'(N - 1);
        end
        else begin
            mem_req_valid_o <= grant_valid;
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
        end
    end

    // The FIFO index doubles as the request id
    always_ff @(posedge ap_clk) begin
        if (grant_valid) begin
            {mem_req_addr_o, mem_req_data_o} <= fifo_dout[grant_idx];
            mem_req_id_o                     <= grant_idx;
        end
    end

endmodule : memory_request_arbiter

//--- design/sync_fifo.sv
// Push when full or pop when empty is not guarded and corrupts the stored entries
module sync_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_lane_template,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Head entry is visible while not empty
    assign pop_data_o = mem[rd_ptr];
    assign empty_o    = (count == '0);

endmodule : sync_fifo
